/* design/sdram_pkg.sv */
package sdram_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [15:0] lane_t;
  typedef logic [12:0] row_t;
  typedef logic [8:0]  col_t;
  typedef logic [1:0]  bank_t;
  typedef logic [1:0]  dqm_t;        // one mask bit per byte of a lane
  typedef logic [15:0] cycle_cnt_t;

  // byte address split
  localparam int COL_LSB    = 2;
  localparam int BANK_LSB   = 11;
  localparam int ROW_LSB    = 13;
  localparam int WINDOW_LSB = 26;    // everything from here up must be zero

  // {ras, cas, we}, all active low on the pins
  typedef enum logic [2:0] {
    cmd_load_mode     = 3'b000,
    cmd_refresh       = 3'b001,
    cmd_precharge_all = 3'b010,
    cmd_active        = 3'b011,
    cmd_write         = 3'b100,
    cmd_read          = 3'b101,
    cmd_nop           = 3'b111
  } sdram_cmd_e;

  typedef enum logic [3:0] {
    st_init_wait,
    st_init_precharge,
    st_init_refresh,
    st_init_mode,
    st_idle,
    st_refresh,
    st_activate,
    st_rw,
    st_done_wait
  } engine_state_e;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } mem_req_s;

  typedef struct packed {
    logic  accept;
    logic  ack;
    data_t rdata;
  } mem_rsp_s;

  typedef struct packed {
    logic       cke;
    logic       cs;
    sdram_cmd_e cmd;
    row_t       addr;
    bank_t      ba;
  } pin_cmd_s;

  typedef struct packed {
    lane_t dout;
    lane_t updout;
    dqm_t  dqm;
    dqm_t  updqm;
    logic  en;
  } wr_lane_s;

endpackage

/* design/sdram_apb_bridge.sv */
`timescale 1ns/100ps

module sdram_apb_bridge (
  input  logic                 clock_i,
  input  logic                 reset_i,
  input  sdram_pkg::addr_t     paddr_i,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic [2:0]           pprot_i,     // protection attributes not used
  input  logic                 pwrite_i,
  input  sdram_pkg::data_t     pwdata_i,
  input  sdram_pkg::strb_t     pstrb_i,
  output logic                 pready_o,
  output sdram_pkg::data_t     prdata_o,
  output logic                 pslverr_o,
  output sdram_pkg::mem_req_s  req_o,
  input  sdram_pkg::mem_rsp_s  rsp_i
);

  typedef enum logic [1:0] {
    idle,
    wait_accept,
    wait_ack
  } bridge_state_e;

  bridge_state_e state_q;
  logic          err_q;
  logic          setup;
  logic          in_window;

  assign setup     = psel_i && !penable_i;
  assign in_window = (paddr_i >> sdram_pkg::WINDOW_LSB) == '0;

  // APB keeps address and data stable until pready, so they pass straight on
  assign req_o.valid = (state_q == idle && setup && in_window) || state_q == wait_accept;
  assign req_o.write = pwrite_i;
  assign req_o.addr  = paddr_i;
  assign req_o.wdata = pwdata_i;
  assign req_o.strb  = pstrb_i;

  assign pready_o  = (state_q == wait_ack) && (err_q || rsp_i.ack);
  assign pslverr_o = (state_q == wait_ack) && err_q;
  assign prdata_o  = rsp_i.rdata;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= idle;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          if (setup) begin
            if (!in_window) begin
              err_q   <= 1'b1;          // answered in the access phase
              state_q <= wait_ack;
            end else if (rsp_i.accept) begin
              state_q <= wait_ack;
            end else begin
              state_q <= wait_accept;
            end
          end
        end
        wait_accept: begin
          if (rsp_i.accept) state_q <= wait_ack;
        end
        wait_ack: begin
          if (pready_o) begin
            err_q   <= 1'b0;
            state_q <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

endmodule

/* design/sdram_cmd_engine.sv */
`timescale 1ns/100ps

module sdram_cmd_engine #(
  parameter int T_RCD          = 2,
  parameter int T_RP           = 2,
  parameter int T_RFC          = 7,
  parameter int CAS_LATENCY    = 2,
  parameter int REFRESH_CYCLES = 780,
  parameter int INIT_CYCLES    = 200
) (
  input  logic                 clock_i,
  input  logic                 reset_i,
  input  sdram_pkg::mem_req_s  req_i,
  output sdram_pkg::mem_rsp_s  rsp_o,
  output sdram_pkg::pin_cmd_s  pin_o,
  output sdram_pkg::wr_lane_s  wr_o,
  output logic                 rd_strobe_o,
  input  logic                 rd_valid_i,
  input  sdram_pkg::data_t     rd_data_i
);

  localparam int T_MRD = 2;
  // longest access that can start just before the refresh falls due
  localparam int REF_MARGIN = T_RCD + CAS_LATENCY + T_RP + 8;
  localparam int REF_LIMIT  = REFRESH_CYCLES - REF_MARGIN;
  // burst length 1, sequential, CAS latency in A6..A4
  localparam sdram_pkg::row_t MODE_WORD    = {6'b000000, 3'(CAS_LATENCY), 4'b0000};
  localparam sdram_pkg::row_t A10_ONLY     = 13'h0400;

  sdram_pkg::engine_state_e state_q, state_d;
  sdram_pkg::cycle_cnt_t    cnt_q, cnt_d;
  sdram_pkg::cycle_cnt_t    ref_cnt_q;
  sdram_pkg::pin_cmd_s      pin_q, pin_d;
  logic                     init_ref_q, init_ref_d;
  logic                     rd_strobe_q, rd_strobe_d;
  logic                     ack_q, ack_d;
  logic                     accept;
  logic                     ref_due;
  logic                     ref_issue;

  sdram_pkg::row_t  req_row;
  sdram_pkg::bank_t req_bank;
  sdram_pkg::col_t  req_col;

  logic             write_q;
  sdram_pkg::bank_t bank_q;
  sdram_pkg::col_t  col_q;
  sdram_pkg::data_t wdata_q;
  sdram_pkg::strb_t strb_q;
  sdram_pkg::data_t rdata_q;

  assign req_row  = sdram_pkg::row_t'(req_i.addr >> sdram_pkg::ROW_LSB);
  assign req_bank = sdram_pkg::bank_t'(req_i.addr >> sdram_pkg::BANK_LSB);
  assign req_col  = sdram_pkg::col_t'(req_i.addr >> sdram_pkg::COL_LSB);

  assign ref_due = ref_cnt_q >= sdram_pkg::cycle_cnt_t'(REF_LIMIT);

  always_comb begin
    state_d     = state_q;
    cnt_d       = (cnt_q != '0) ? cnt_q - 1'b1 : cnt_q;
    init_ref_d  = init_ref_q;
    pin_d       = '{cke: 1'b1, cs: 1'b0, cmd: sdram_pkg::cmd_nop, addr: '0, ba: '0};
    rd_strobe_d = 1'b0;
    ack_d       = 1'b0;
    accept      = 1'b0;
    ref_issue   = 1'b0;
    wr_o        = '{dout: wdata_q[15:0], updout: wdata_q[31:16],
                    dqm: ~strb_q[1:0], updqm: ~strb_q[3:2], en: 1'b0};

    case (state_q)
      sdram_pkg::st_init_wait: begin
        pin_d.cke = 1'b0;
        if (cnt_q == '0) begin
          pin_d.cke  = 1'b1;
          pin_d.cmd  = sdram_pkg::cmd_precharge_all;
          pin_d.addr = A10_ONLY;
          cnt_d      = sdram_pkg::cycle_cnt_t'(T_RP - 1);
          state_d    = sdram_pkg::st_init_precharge;
        end
      end
      sdram_pkg::st_init_precharge: begin
        if (cnt_q == '0) begin
          pin_d.cmd  = sdram_pkg::cmd_refresh;
          ref_issue  = 1'b1;
          init_ref_d = 1'b0;
          cnt_d      = sdram_pkg::cycle_cnt_t'(T_RFC - 1);
          state_d    = sdram_pkg::st_init_refresh;
        end
      end
      sdram_pkg::st_init_refresh: begin
        if (cnt_q == '0 && !init_ref_q) begin
          pin_d.cmd  = sdram_pkg::cmd_refresh;   // second of the two
          ref_issue  = 1'b1;
          init_ref_d = 1'b1;
          cnt_d      = sdram_pkg::cycle_cnt_t'(T_RFC - 1);
        end else if (cnt_q == '0) begin
          pin_d.cmd  = sdram_pkg::cmd_load_mode;
          pin_d.addr = MODE_WORD;
          cnt_d      = sdram_pkg::cycle_cnt_t'(T_MRD - 1);
          state_d    = sdram_pkg::st_init_mode;
        end
      end
      sdram_pkg::st_init_mode: begin
        if (cnt_q == '0) state_d = sdram_pkg::st_idle;
      end
      sdram_pkg::st_idle: begin
        if (ref_due) begin               // refresh wins over a waiting request
          pin_d.cmd = sdram_pkg::cmd_refresh;
          ref_issue = 1'b1;
          cnt_d     = sdram_pkg::cycle_cnt_t'(T_RFC - 1);
          state_d   = sdram_pkg::st_refresh;
        end else if (req_i.valid) begin
          accept     = 1'b1;
          pin_d.cmd  = sdram_pkg::cmd_active;
          pin_d.addr = req_row;
          pin_d.ba   = req_bank;
          cnt_d      = sdram_pkg::cycle_cnt_t'(T_RCD - 1);
          state_d    = sdram_pkg::st_activate;
        end
      end
      sdram_pkg::st_refresh: begin
        if (cnt_q == '0) state_d = sdram_pkg::st_idle;
      end
      sdram_pkg::st_activate: begin
        if (cnt_q == '0) begin
          pin_d.addr = {2'b00, 1'b1, 1'b0, col_q};  // A10 high, auto-precharge
          pin_d.ba   = bank_q;
          if (write_q) begin
            pin_d.cmd = sdram_pkg::cmd_write;
            wr_o.en   = 1'b1;            // data path registers it with the command
          end else begin
            pin_d.cmd   = sdram_pkg::cmd_read;
            rd_strobe_d = 1'b1;
          end
          state_d = sdram_pkg::st_rw;
        end
      end
      sdram_pkg::st_rw: begin
        if (write_q) begin
          ack_d   = 1'b1;
          cnt_d   = sdram_pkg::cycle_cnt_t'(T_RP);  // one extra cycle for write recovery
          state_d = sdram_pkg::st_done_wait;
        end else if (rd_valid_i) begin
          ack_d   = 1'b1;
          cnt_d   = sdram_pkg::cycle_cnt_t'(T_RP - 1);
          state_d = sdram_pkg::st_done_wait;
        end
      end
      sdram_pkg::st_done_wait: begin
        if (cnt_q == '0) state_d = sdram_pkg::st_idle;
      end
      default: state_d = sdram_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q     <= sdram_pkg::st_init_wait;
      cnt_q       <= sdram_pkg::cycle_cnt_t'(INIT_CYCLES - 1);
      ref_cnt_q   <= '0;
      init_ref_q  <= 1'b0;
      pin_q       <= '{cke: 1'b0, cs: 1'b1, cmd: sdram_pkg::cmd_nop, addr: '0, ba: '0};
      rd_strobe_q <= 1'b0;
      ack_q       <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      init_ref_q  <= init_ref_d;
      pin_q       <= pin_d;
      rd_strobe_q <= rd_strobe_d;
      ack_q       <= ack_d;
      if (ref_issue) ref_cnt_q <= '0;
      else if (!ref_due) ref_cnt_q <= ref_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clock_i) begin
    if (accept) begin
      write_q <= req_i.write;
      bank_q  <= req_bank;
      col_q   <= req_col;
      wdata_q <= req_i.wdata;
      strb_q  <= req_i.strb;
    end
    if (rd_valid_i) rdata_q <= rd_data_i;
  end

  assign rsp_o       = '{accept: accept, ack: ack_q, rdata: rdata_q};
  assign pin_o       = pin_q;
  assign rd_strobe_o = rd_strobe_q;

endmodule

/* design/sdram_dq_path.sv */
`timescale 1ns/100ps

module sdram_dq_path #(
  parameter int CAS_LATENCY = 2
) (
  input  logic                 clock_i,
  input  logic                 reset_i,
  input  sdram_pkg::wr_lane_s  wr_i,
  input  logic                 rd_strobe_i,
  input  sdram_pkg::lane_t     dq_i,
  input  sdram_pkg::lane_t     updq_i,
  output sdram_pkg::lane_t     dout_o,
  output sdram_pkg::lane_t     updout_o,
  output logic                 dout_en_o,
  output sdram_pkg::dqm_t      dqm_o,
  output sdram_pkg::dqm_t      updqm_o,
  output logic                 rd_valid_o,
  output sdram_pkg::data_t     rd_data_o
);

  // one bit per cycle since the read command, so reads may overlap
  logic [CAS_LATENCY:0] rd_pipe_q;
  sdram_pkg::lane_t     dq_q;
  sdram_pkg::lane_t     updq_q;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      dout_en_o <= 1'b0;
      dqm_o     <= '0;
      updqm_o   <= '0;
      rd_pipe_q <= '0;
    end else begin
      dout_en_o <= wr_i.en;
      dqm_o     <= wr_i.en ? wr_i.dqm : '0;   // reads want every byte
      updqm_o   <= wr_i.en ? wr_i.updqm : '0;
      rd_pipe_q <= {rd_pipe_q[CAS_LATENCY-1:0], rd_strobe_i};
    end
  end

  always_ff @(posedge clock_i) begin
    dout_o   <= wr_i.dout;
    updout_o <= wr_i.updout;
    dq_q     <= dq_i;    // input register, the extra cycle
    updq_q   <= updq_i;
  end

  assign rd_valid_o = rd_pipe_q[CAS_LATENCY];
  assign rd_data_o  = {updq_q, dq_q};

endmodule

/* design/sdram_apb_top.sv */
`timescale 1ns/100ps

module sdram_apb_top #(
  parameter int T_RCD          = 2,
  parameter int T_RP           = 2,
  parameter int T_RFC          = 7,
  parameter int CAS_LATENCY    = 2,
  parameter int REFRESH_CYCLES = 780,
  parameter int INIT_CYCLES    = 200
) (
  input  logic              clock_i,
  input  logic              reset_i,
  input  sdram_pkg::addr_t  paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic [2:0]        pprot_i,
  input  logic              pwrite_i,
  input  sdram_pkg::data_t  pwdata_i,
  input  sdram_pkg::strb_t  pstrb_i,
  output logic              pready_o,
  output sdram_pkg::data_t  prdata_o,
  output logic              pslverr_o,

  output logic              sdram_clk_o,
  output logic              sdram_cke_o,
  output logic              sdram_cs_o,
  output logic              sdram_cs1_o,
  output logic              sdram_ras_o,
  output logic              sdram_cas_o,
  output logic              sdram_we_o,
  output sdram_pkg::row_t   sdram_a_o,
  output sdram_pkg::bank_t  sdram_ba_o,
  output sdram_pkg::dqm_t   sdram_dqm_o,
  output sdram_pkg::dqm_t   sdram_updqm_o,
  inout  wire [15:0]        sdram_dq,
  inout  wire [15:0]        sdram_updq
);

  sdram_pkg::mem_req_s req;
  sdram_pkg::mem_rsp_s rsp;
  sdram_pkg::pin_cmd_s pin;
  sdram_pkg::wr_lane_s wr;
  logic                rd_strobe;
  logic                rd_valid;
  sdram_pkg::data_t    rd_data;
  sdram_pkg::lane_t    dout;
  sdram_pkg::lane_t    updout;
  logic                dout_en;

  assign sdram_dq   = dout_en ? dout : 16'bz;
  assign sdram_updq = dout_en ? updout : 16'bz;

  assign sdram_clk_o = clock_i;
  assign sdram_cke_o = pin.cke;
  assign sdram_cs_o  = pin.cs;
  assign sdram_cs1_o = 1'b1;          // second rank never selected
  assign {sdram_ras_o, sdram_cas_o, sdram_we_o} = pin.cmd;
  assign sdram_a_o   = pin.addr;
  assign sdram_ba_o  = pin.ba;

  sdram_apb_bridge bridge_i (
    .clock_i   (clock_i),
    .reset_i   (reset_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pprot_i   (pprot_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pstrb_i   (pstrb_i),
    .pready_o  (pready_o),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .req_o     (req),
    .rsp_i     (rsp)
  );

  sdram_cmd_engine #(
    .T_RCD          (T_RCD),
    .T_RP           (T_RP),
    .T_RFC          (T_RFC),
    .CAS_LATENCY    (CAS_LATENCY),
    .REFRESH_CYCLES (REFRESH_CYCLES),
    .INIT_CYCLES    (INIT_CYCLES)
  ) engine_i (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .req_i       (req),
    .rsp_o       (rsp),
    .pin_o       (pin),
    .wr_o        (wr),
    .rd_strobe_o (rd_strobe),
    .rd_valid_i  (rd_valid),
    .rd_data_i   (rd_data)
  );

  sdram_dq_path #(
    .CAS_LATENCY (CAS_LATENCY)
  ) dq_path_i (
    .clock_i     (clock_i),
    .reset_i     (reset_i),
    .wr_i        (wr),
    .rd_strobe_i (rd_strobe),
    .dq_i        (sdram_dq),
    .updq_i      (sdram_updq),
    .dout_o      (dout),
    .updout_o    (updout),
    .dout_en_o   (dout_en),
    .dqm_o       (sdram_dqm_o),
    .updqm_o     (sdram_updqm_o),
    .rd_valid_o  (rd_valid),
    .rd_data_o   (rd_data)
  );

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #2 clock_o = ~clock_o;   // 4 ns period
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clock_o);
    reset_o <= 1'b0;
  end

endmodule

/* tb/sdram_model.sv */
`timescale 1ns/100ps

module sdram_model #(
  parameter int CAS_LATENCY = 2
) (
  input  logic        clock_i,
  input  logic        cs_i,
  input  logic        ras_i,
  input  logic        cas_i,
  input  logic        we_i,
  input  logic [12:0] a_i,
  input  logic [1:0]  ba_i,
  input  logic [1:0]  dqm_i,
  input  logic [1:0]  updqm_i,
  inout  wire  [15:0] dq,
  inout  wire  [15:0] updq
);

  logic [15:0] lo_mem [int unsigned];
  logic [15:0] hi_mem [int unsigned];
  logic [12:0] open_row [4];
  logic [31:0] rd_word_q [CAS_LATENCY];
  logic [CAS_LATENCY-1:0] rd_busy_q = '0;
  logic [2:0]  cmd;
  int unsigned key;

  assign cmd = {ras_i, cas_i, we_i};
  assign key = {ba_i, open_row[ba_i], a_i[8:0]};

  // data reaches the pins CAS_LATENCY cycles after the read command
  assign dq   = rd_busy_q[CAS_LATENCY-1] ? rd_word_q[CAS_LATENCY-1][15:0]  : 16'bz;
  assign updq = rd_busy_q[CAS_LATENCY-1] ? rd_word_q[CAS_LATENCY-1][31:16] : 16'bz;

  function automatic logic [15:0] masked(logic [15:0] old, logic [15:0] din, logic [1:0] m);
    logic [15:0] res;
    res = old;
    if (!m[0]) res[7:0] = din[7:0];
    if (!m[1]) res[15:8] = din[15:8];
    return res;
  endfunction

  always @(posedge clock_i) begin
    for (int i = CAS_LATENCY - 1; i > 0; i--) begin
      rd_word_q[i] <= rd_word_q[i-1];
    end
    rd_busy_q <= {rd_busy_q[CAS_LATENCY-2:0], 1'b0};
    if (!cs_i) begin
      if (cmd == sdram_pkg::cmd_active) open_row[ba_i] <= a_i;
      if (cmd == sdram_pkg::cmd_write) begin
        lo_mem[key] = masked(lo_mem.exists(key) ? lo_mem[key] : 16'h0, dq, dqm_i);
        hi_mem[key] = masked(hi_mem.exists(key) ? hi_mem[key] : 16'h0, updq, updqm_i);
      end
      if (cmd == sdram_pkg::cmd_read) begin
        rd_word_q[0] <= {hi_mem.exists(key) ? hi_mem[key] : 16'h0,
                         lo_mem.exists(key) ? lo_mem[key] : 16'h0};
        rd_busy_q[0] <= 1'b1;
      end
    end
  end

endmodule

/* tb/sdram_apb_checker.sv */
`timescale 1ns/100ps

module sdram_apb_checker #(
  parameter int T_RCD          = 2,
  parameter int T_RFC          = 7,
  parameter int CAS_LATENCY    = 2,
  parameter int REFRESH_CYCLES = 780
) (
  input logic clock_i,
  input logic reset_i,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic pslverr_i,
  input logic cke_i,
  input logic cs_i,
  input logic cs1_i,
  input logic ras_i,
  input logic cas_i,
  input logic we_i,
  input logic dout_en_i
);

  int                   fail_cnt = 0;
  logic [2:0]           cmd;
  logic                 quiet;
  logic                 mode_seen_q;
  logic [15:0]          since_ref_q;
  logic [15:0]          since_act_q;
  logic [CAS_LATENCY:0] rd_hist_q;

  assign cmd   = {ras_i, cas_i, we_i};
  assign quiet = cs_i || cmd == sdram_pkg::cmd_nop || cmd == sdram_pkg::cmd_refresh;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      mode_seen_q <= 1'b0;
      since_ref_q <= '0;
      since_act_q <= '0;
      rd_hist_q   <= '0;
    end else begin
      if (!cs_i && cmd == sdram_pkg::cmd_load_mode) mode_seen_q <= 1'b1;
      if (!cs_i && cmd == sdram_pkg::cmd_refresh) since_ref_q <= 16'd1;
      else if (since_ref_q != 16'hffff) since_ref_q <= since_ref_q + 1'b1;
      if (!cs_i && cmd == sdram_pkg::cmd_active) since_act_q <= 16'd1;
      else if (since_act_q != 16'hffff) since_act_q <= since_act_q + 1'b1;
      rd_hist_q <= {rd_hist_q[CAS_LATENCY-1:0], !cs_i && cmd == sdram_pkg::cmd_read};
    end
  end

  a_init_order: assert property (@(posedge clock_i) disable iff (reset_i)
    (!cs_i && (cmd == sdram_pkg::cmd_active || cmd == sdram_pkg::cmd_read ||
               cmd == sdram_pkg::cmd_write)) |-> mode_seen_q)
    else begin $error("access command before load mode"); fail_cnt++; end

  // clock enable stays low through the power-up wait and wakes with precharge all
  a_cke_wake: assert property (@(posedge clock_i) disable iff (reset_i)
    (!cs_i && cmd == sdram_pkg::cmd_precharge_all && !mode_seen_q)
      |-> cke_i && !$past(cke_i))
    else begin $error("cke not low until the init precharge"); fail_cnt++; end

  a_cke_hold: assert property (@(posedge clock_i) disable iff (reset_i)
    cke_i |=> cke_i)
    else begin $error("cke dropped after wake-up"); fail_cnt++; end

  a_cs1_off: assert property (@(posedge clock_i) disable iff (reset_i)
    cs1_i)
    else begin $error("second chip select driven active"); fail_cnt++; end

  a_err_quiet: assert property (@(posedge clock_i) disable iff (reset_i)
    (pready_i && pslverr_i) |-> quiet ##1 quiet)
    else begin $error("sdram command issued for an error access"); fail_cnt++; end

  a_refresh: assert property (@(posedge clock_i) disable iff (reset_i)
    since_ref_q <= 16'(REFRESH_CYCLES + T_RFC))
    else begin $error("refresh interval exceeded"); fail_cnt++; end

  a_trcd: assert property (@(posedge clock_i) disable iff (reset_i)
    (!cs_i && (cmd == sdram_pkg::cmd_read || cmd == sdram_pkg::cmd_write))
      |-> since_act_q >= 16'(T_RCD))
    else begin $error("read or write too soon after active"); fail_cnt++; end

  a_ready_phase: assert property (@(posedge clock_i) disable iff (reset_i)
    pready_i |-> psel_i && penable_i)
    else begin $error("pready outside the access phase"); fail_cnt++; end

  a_ready_pulse: assert property (@(posedge clock_i) disable iff (reset_i)
    pready_i |=> !pready_i)
    else begin $error("pready longer than one cycle"); fail_cnt++; end

  a_err_ready: assert property (@(posedge clock_i) disable iff (reset_i)
    pslverr_i |-> pready_i)
    else begin $error("pslverr without pready"); fail_cnt++; end

  a_dq_turn: assert property (@(posedge clock_i) disable iff (reset_i)
    (rd_hist_q != '0) |-> !dout_en_i)
    else begin $error("dq driven during a read window"); fail_cnt++; end

endmodule

/* tb/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

  localparam int TIMEOUT = 2000;

  logic clock, reset;
  sdram_pkg::addr_t paddr;
  logic             psel, penable, pwrite;
  logic [2:0]       pprot;
  sdram_pkg::data_t pwdata, prdata;
  sdram_pkg::strb_t pstrb;
  logic             pready, pslverr;
  logic             s_clk, s_cke, s_cs, s_cs1, s_ras, s_cas, s_we;
  logic [12:0]      s_a;
  logic [1:0]       s_ba, s_dqm, s_updqm;
  wire  [15:0]      sdram_dq, sdram_updq;

  sdram_pkg::data_t shadow [int unsigned];
  sdram_pkg::addr_t addrs [16];
  int               errors = 0;
  int               checks = 0;
  int               tests = 0;
  logic             timed_out = 1'b0;

  tb_clock_gen clock_gen_i (.clock_o(clock), .reset_o(reset));

  sdram_apb_top dut_i (
    .clock_i(clock), .reset_i(reset), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
    .pprot_i(pprot), .pwrite_i(pwrite), .pwdata_i(pwdata), .pstrb_i(pstrb),
    .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
    .sdram_clk_o(s_clk), .sdram_cke_o(s_cke), .sdram_cs_o(s_cs), .sdram_cs1_o(s_cs1),
    .sdram_ras_o(s_ras), .sdram_cas_o(s_cas), .sdram_we_o(s_we), .sdram_a_o(s_a),
    .sdram_ba_o(s_ba), .sdram_dqm_o(s_dqm), .sdram_updqm_o(s_updqm),
    .sdram_dq(sdram_dq), .sdram_updq(sdram_updq)
  );

  sdram_model #(.CAS_LATENCY(2)) model_i (
    .clock_i(s_clk), .cs_i(s_cs), .ras_i(s_ras), .cas_i(s_cas), .we_i(s_we), .a_i(s_a),
    .ba_i(s_ba), .dqm_i(s_dqm), .updqm_i(s_updqm), .dq(sdram_dq), .updq(sdram_updq)
  );

  bind sdram_apb_top sdram_apb_checker #(
    .T_RCD(T_RCD), .T_RFC(T_RFC), .CAS_LATENCY(CAS_LATENCY), .REFRESH_CYCLES(REFRESH_CYCLES)
  ) checker_i (
    .clock_i(clock_i), .reset_i(reset_i), .psel_i(psel_i), .penable_i(penable_i),
    .pready_i(pready_o), .pslverr_i(pslverr_o), .cke_i(sdram_cke_o), .cs_i(sdram_cs_o),
    .cs1_i(sdram_cs1_o), .ras_i(sdram_ras_o), .cas_i(sdram_cas_o), .we_i(sdram_we_o),
    .dout_en_i(dout_en)
  );

  function automatic sdram_pkg::addr_t rand_addr();
    return {6'b0, 24'($urandom), 2'b00};   // inside the 64 MiB window
  endfunction

  function automatic sdram_pkg::data_t merge_bytes(sdram_pkg::data_t old,
                                                   sdram_pkg::data_t din,
                                                   sdram_pkg::strb_t strb);
    sdram_pkg::data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = din[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_value(string name, sdram_pkg::data_t exp, sdram_pkg::data_t act);
    checks++;
    assert (exp == act)
      else begin
        $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        errors++;
      end
  endtask

  task automatic apb_access(input logic write, input sdram_pkg::addr_t addr,
                            input sdram_pkg::data_t wdata, input sdram_pkg::strb_t strb,
                            output sdram_pkg::data_t rdata, output logic err);
    int n;
    rdata = '0;
    err   = 1'b0;
    if (timed_out) return;
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge clock);
    penable <= 1'b1;
    n = 0;
    @(negedge clock);
    while (!pready && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!pready) begin
      $display("timeout: no pready for address %h within %0d cycles", addr, TIMEOUT);
      timed_out = 1'b1;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic write_word(string name, sdram_pkg::addr_t addr, sdram_pkg::data_t data,
                            sdram_pkg::strb_t strb);
    sdram_pkg::data_t rd;
    logic             err;
    int unsigned      k;
    apb_access(1'b1, addr, data, strb, rd, err);
    check_value(name, 32'h0, 32'(err));
    k = addr >> 2;
    shadow[k] = merge_bytes(shadow.exists(k) ? shadow[k] : 32'h0, data, strb);
  endtask

  task automatic read_check(string name, sdram_pkg::addr_t addr);
    sdram_pkg::data_t rd;
    logic             err;
    int unsigned      k;
    apb_access(1'b0, addr, '0, '0, rd, err);
    k = addr >> 2;
    check_value(name, 32'h0, 32'(err));
    check_value(name, shadow.exists(k) ? shadow[k] : 32'h0, rd);
  endtask

  task automatic finish_test(string name, int errors_before);
    tests++;
    $display("test %-12s done, %0d errors", name, errors - errors_before);
  endtask

  initial begin
    int               e0;
    int               n;
    sdram_pkg::addr_t a;
    sdram_pkg::data_t rd;
    logic             err;
    void'($urandom(32'h6ebb34a2));
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pprot   <= 3'b000;
    paddr   <= '0;
    pwdata  <= '0;
    pstrb   <= '0;
    n = 0;
    do begin
      @(posedge clock);
      n++;
    end while (reset && n < TIMEOUT);
    if (reset) begin
      $display("timeout: reset still high after %0d cycles", TIMEOUT);
      timed_out = 1'b1;
    end

    e0 = errors;                     // issued while init is still running
    a  = rand_addr();
    write_word("init_first", a, $urandom, 4'hf);
    read_check("init_first", a);
    finish_test("init_first", e0);

    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = rand_addr();
      write_word("full_word", addrs[i], $urandom, 4'hf);
    end
    for (int i = 0; i < 16; i++) read_check("full_word", addrs[i]);
    finish_test("full_word", e0);

    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      write_word("partial", addrs[i], $urandom, 4'($urandom));
      read_check("partial", addrs[i]);
    end
    finish_test("partial", e0);

    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      a = rand_addr() | (32'h1 << (26 + ($urandom % 6)));
      apb_access(i[0], a, $urandom, 4'hf, rd, err);
      check_value("slverr", 32'h1, 32'(err));
    end
    finish_test("slverr", e0);

    e0 = errors;
    repeat (2500) @(posedge clock);  // idle stretch over several refresh periods
    for (int i = 0; i < 32; i++) begin
      a = ($urandom % 2) ? addrs[$urandom % 16] : rand_addr();
      if ($urandom % 2) write_word("stream", a, $urandom, 4'($urandom));
      else read_check("stream", a);
    end
    finish_test("stream", e0);

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, dut_i.checker_i.fail_cnt);
    if (!timed_out && errors == 0 && dut_i.checker_i.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tb.f */
design/sdram_pkg.sv
design/sdram_apb_bridge.sv
design/sdram_cmd_engine.sv
design/sdram_dq_path.sv
design/sdram_apb_top.sv
tb/tb_clock_gen.sv
tb/sdram_model.sv
tb/sdram_apb_checker.sv
tb/tb_top.sv

/* Makefile */
SIM  = obj_dir/Vtb_top
SRCS = $(shell cat tb.f)

$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_top -f tb.f

.PHONY: run clean

run: $(SIM)
	$(SIM) +verilator+error+limit+1000 | tee sim.log
	@! grep -q "Regression failed" sim.log
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
